/* hdl/mul_pkg.sv */
package mul_pkg;

    // wishbone word and register word address
    typedef logic [31:0] wb_data_t;
    typedef logic [2:0]  wb_addr_t;

    // register map, word offsets
    localparam wb_addr_t REG_OP_A   = 3'd0;
    localparam wb_addr_t REG_OP_B   = 3'd1;
    localparam wb_addr_t REG_CMD    = 3'd2;
    localparam wb_addr_t REG_STATUS = 3'd3;
    localparam wb_addr_t REG_PROD   = 3'd4;
    localparam wb_addr_t REG_ACC_LO = 3'd5;
    localparam wb_addr_t REG_ACC_HI = 3'd6;

    // command register bits
    localparam int unsigned CMD_START = 0;
    localparam int unsigned CMD_ACCUM = 1;
    // clear takes effect before a start issued in the same write
    localparam int unsigned CMD_CLEAR = 2;

    // status register bits
    localparam int unsigned ST_BUSY = 0;
    localparam int unsigned ST_DONE = 1;

    // extra accumulator bits above the product width
    localparam int unsigned GUARD_BITS = 8;

endpackage

/* hdl/baugh_wooley_mul.sv */
module baugh_wooley_mul
#(
    parameter int IB = 16,
    parameter int OB = 2 * IB
)
(
    input  logic [IB-1:0] a,
    input  logic [IB-1:0] b,
    output logic [OB-1:0] product
);

    // one generate block per partial-product row
    // row r holds a * b[r] shifted left by r, with the baugh-wooley inversions
    // rows 1 and up add themselves onto the running sum of the rows above
    for (genvar r = 0; r < IB; r++)
    begin : g_row
        logic [OB-1:0] pp;
        logic [OB-1:0] sum;

        // AND cells, NAND where exactly one of the two bits is a sign bit
        // so the last row is inverted except at its own sign column
        always_comb
        begin
            pp = '0;
            for (int j = 0; j < IB; j++)
            begin
                pp[r + j] = (a[j] & b[r]) ^ ((r == IB - 1) != (j == IB - 1));
            end
        end

        if (r == 0)
        begin : g_seed
            // the two correction ones sit in free columns of the first row
            assign sum = pp | (OB'(1) << IB) | (OB'(1) << (OB - 1));
        end
        else
        begin : g_add
            logic [OB-1:0] sum_in;

            assign sum_in = g_row[r-1].sum;

            // ripple of adder cells across the row, carry out of the top column is dropped
            always_comb
            begin
                logic carry;
                logic s_ab;

                carry = 1'b0;
                sum   = '0;
                for (int c = 0; c < OB; c++)
                begin
                    if (c < r)
                    begin
                        // below this row's first column, pass the upper sum through
                        sum[c] = sum_in[c];
                    end
                    else if (c == r)
                    begin
                        // half adder cell, no carry in yet
                        sum[c] = sum_in[c] ^ pp[c];
                        carry  = sum_in[c] & pp[c];
                    end
                    else if (c > r + IB - 1)
                    begin
                        // half adder cell, row has no partial product here
                        sum[c] = sum_in[c] ^ carry;
                        carry  = sum_in[c] & carry;
                    end
                    else
                    begin
                        // full adder cell
                        s_ab   = sum_in[c] ^ pp[c];
                        sum[c] = s_ab ^ carry;
                        carry  = (sum_in[c] & pp[c]) | (carry & s_ab);
                    end
                end
            end
        end
    end

    // modulo 2^OB this is the exact two's complement product
    assign product = g_row[IB-1].sum;

endmodule

/* hdl/mac_datapath.sv */
module mac_datapath
#(
    parameter int IB  = 16,
    parameter int OB  = 2 * IB,
    parameter int ACW = OB + mul_pkg::GUARD_BITS
)
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic [IB-1:0]  op_a,
    input  logic [IB-1:0]  op_b,
    input  logic           launch,
    input  logic           accum,
    input  logic           clear,
    output logic [OB-1:0]  product,
    output logic [ACW-1:0] acc,
    output logic           busy,
    output logic           done_pulse
);

    logic [OB-1:0]         mul_out;
    logic [OB-1:0]         prod_q;
    logic                  s1_valid;
    logic                  s1_accum;
    logic signed [ACW-1:0] prod_ext;
    logic [ACW-1:0]        acc_base;

    baugh_wooley_mul #(
        .IB (IB),
        .OB (OB)
    ) u_mul (
        .a       (op_a),
        .b       (op_b),
        .product (mul_out)
    );

    // stage one: capture the array output and the mode that goes with it
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            s1_valid <= 1'b0;
            s1_accum <= 1'b0;
            prod_q   <= '0;
        end
        else
        begin
            s1_valid <= launch;
            if (launch)
            begin
                prod_q   <= mul_out;
                s1_accum <= accum;
            end
        end
    end

    assign prod_ext = $signed(prod_q);

    // a clear on the same edge means the add starts from zero
    assign acc_base = clear ? '0 : acc;

    // stage two: load or add into the accumulator
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            acc <= '0;
        end
        else if (s1_valid)
        begin
            acc <= s1_accum ? acc_base + prod_ext : prod_ext;
        end
        else if (clear)
        begin
            acc <= '0;
        end
    end

    assign product    = prod_q;
    // item entering the pipe or waiting in stage one
    assign busy       = launch | s1_valid;
    assign done_pulse = s1_valid;

endmodule

/* hdl/mul_regs.sv */
module mul_regs
#(
    parameter int IB  = 16,
    parameter int OB  = 2 * IB,
    parameter int ACW = OB + mul_pkg::GUARD_BITS
)
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  mul_pkg::wb_addr_t adr,
    input  mul_pkg::wb_data_t dat_w,
    output mul_pkg::wb_data_t dat_r,
    output logic              ack,
    output logic [IB-1:0]     op_a,
    output logic [IB-1:0]     op_b,
    output logic              launch,
    output logic              accum,
    output logic              clear,
    input  logic [OB-1:0]     product,
    input  logic [ACW-1:0]    acc,
    input  logic              busy,
    input  logic              done_pulse
);

    localparam int DW = $bits(mul_pkg::wb_data_t);

    logic              bus_req;
    logic              wr_en;
    logic              cmd_wr;
    logic              done_q;
    logic [2*DW-1:0]   acc_ext;
    mul_pkg::wb_data_t rd_mux;

    // a new request is one not yet acknowledged
    assign bus_req = cyc & stb & ~ack;
    assign wr_en   = bus_req & we;
    assign cmd_wr  = wr_en && (adr == mul_pkg::REG_CMD);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ack <= 1'b0;
        end
        else
        begin
            ack <= bus_req;
        end
    end

    // operand and command registers, pulses fire on the acknowledging edge
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            op_a   <= '0;
            op_b   <= '0;
            accum  <= 1'b0;
            launch <= 1'b0;
            clear  <= 1'b0;
        end
        else
        begin
            launch <= cmd_wr & dat_w[mul_pkg::CMD_START];
            clear  <= cmd_wr & dat_w[mul_pkg::CMD_CLEAR];
            if (wr_en)
            begin
                case (adr)
                    mul_pkg::REG_OP_A: op_a  <= dat_w[IB-1:0];
                    mul_pkg::REG_OP_B: op_b  <= dat_w[IB-1:0];
                    mul_pkg::REG_CMD:  accum <= dat_w[mul_pkg::CMD_ACCUM];
                    default:           ;
                endcase
            end
        end
    end

    // sticky done, a new launch clears it
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            done_q <= 1'b0;
        end
        else if (launch)
        begin
            done_q <= 1'b0;
        end
        else if (done_pulse)
        begin
            done_q <= 1'b1;
        end
    end

    assign acc_ext = $signed(acc);

    always_comb
    begin
        rd_mux = '0;
        case (adr)
            mul_pkg::REG_OP_A:   rd_mux = mul_pkg::wb_data_t'(op_a);
            mul_pkg::REG_OP_B:   rd_mux = mul_pkg::wb_data_t'(op_b);
            mul_pkg::REG_STATUS:
            begin
                rd_mux[mul_pkg::ST_BUSY] = busy;
                rd_mux[mul_pkg::ST_DONE] = done_q;
            end
            mul_pkg::REG_PROD:   rd_mux = mul_pkg::wb_data_t'($signed(product));
            mul_pkg::REG_ACC_LO: rd_mux = acc_ext[DW-1:0];
            mul_pkg::REG_ACC_HI: rd_mux = acc_ext[2*DW-1:DW];
            default:             rd_mux = '0;
        endcase
    end

    // read data is valid alongside ack
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dat_r <= '0;
        end
        else if (bus_req && !we)
        begin
            dat_r <= rd_mux;
        end
    end

endmodule

/* hdl/mul_top.sv */
module mul_top
#(
    parameter int IB = 16
)
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  mul_pkg::wb_addr_t adr,
    input  mul_pkg::wb_data_t dat_w,
    output mul_pkg::wb_data_t dat_r,
    output logic              ack
);

    // product width and accumulator width with guard bits
    localparam int OB  = 2 * IB;
    localparam int ACW = OB + mul_pkg::GUARD_BITS;

    logic [IB-1:0]  op_a;
    logic [IB-1:0]  op_b;
    logic           launch;
    logic           accum;
    logic           clear;
    logic [OB-1:0]  product;
    logic [ACW-1:0] acc;
    logic           busy;
    logic           done_pulse;

    mul_regs #(
        .IB  (IB),
        .OB  (OB),
        .ACW (ACW)
    ) u_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .op_a       (op_a),
        .op_b       (op_b),
        .launch     (launch),
        .accum      (accum),
        .clear      (clear),
        .product    (product),
        .acc        (acc),
        .busy       (busy),
        .done_pulse (done_pulse)
    );

    mac_datapath #(
        .IB  (IB),
        .OB  (OB),
        .ACW (ACW)
    ) u_datapath (
        .clk        (clk),
        .arst_n     (arst_n),
        .op_a       (op_a),
        .op_b       (op_b),
        .launch     (launch),
        .accum      (accum),
        .clear      (clear),
        .product    (product),
        .acc        (acc),
        .busy       (busy),
        .done_pulse (done_pulse)
    );

endmodule

/* tests/tb_wb_tasks.svh */
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// wishbone master tasks, each cycle starts on a falling edge
// and returns on the falling edge where ack was seen

localparam int ACK_TIMEOUT  = 20;
localparam int IDLE_TIMEOUT = 50;

// ack is checked only on falling edges, where it is stable
task automatic wait_ack();
    int n;
    n = 0;
    while (ack !== 1'b1 && n < ACK_TIMEOUT)
    begin
        @(negedge clk);
        n++;
    end
    if (ack !== 1'b1)
    begin
        stop_on_error("no ack from the DUT within the bus timeout");
    end
endtask

task automatic bus_write(input mul_pkg::wb_addr_t addr, input mul_pkg::wb_data_t data);
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = addr;
    dat_w = data;
    wait_ack();
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
endtask

task automatic bus_read(input mul_pkg::wb_addr_t addr, output mul_pkg::wb_data_t data);
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = addr;
    wait_ack();
    // dat_r is registered on the same edge as ack
    data = dat_r;
    cyc  = 1'b0;
    stb  = 1'b0;
endtask

// poll STATUS until the busy bit drops
task automatic wait_idle(output mul_pkg::wb_data_t status);
    int n;
    n = 0;
    bus_read(mul_pkg::REG_STATUS, status);
    while (status[mul_pkg::ST_BUSY] && n < IDLE_TIMEOUT)
    begin
        bus_read(mul_pkg::REG_STATUS, status);
        n++;
    end
    if (status[mul_pkg::ST_BUSY])
    begin
        stop_on_error("DUT stayed busy past the polling timeout");
    end
endtask

`endif

/* tests/tb_mul_top.sv */
module tb_mul_top;

    localparam int          IB         = 16;
    localparam int          ACW        = 2 * IB + mul_pkg::GUARD_BITS;
    localparam logic [31:0] LCG_SEED   = 32'h06c8_6a45;
    localparam int          RAND_PAIRS = 200;
    localparam int          CHAIN_LEN  = 50;

    logic              clk;
    logic              arst_n;
    logic              cyc;
    logic              stb;
    logic              we;
    mul_pkg::wb_addr_t adr;
    mul_pkg::wb_data_t dat_w;
    mul_pkg::wb_data_t dat_r;
    logic              ack;

    logic [31:0]       lcg_state;
    logic [ACW-1:0]    model_acc;
    mul_pkg::wb_data_t model_prod;

    // reads waiting for the compare process
    string             chk_name_q[$];
    mul_pkg::wb_data_t chk_exp_q[$];
    mul_pkg::wb_data_t chk_got_q[$];

    mul_top #(
        .IB (IB)
    ) dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack)
    );

    always #10 clk = ~clk;

    task automatic stop_on_error(input string what);
        $display("[ERROR] %s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    `include "tb_wb_tasks.svh"

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // halves swapped so operand bits come from the better upper state bits
    function automatic mul_pkg::wb_data_t rand_word();
        lcg_state = lcg_step(lcg_state);
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    // signed 16x16 product sign-extended to 32 bits
    function automatic mul_pkg::wb_data_t ref_product(input logic [15:0] a, input logic [15:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = {{16{a[15]}}, a};
        sb = {{16{b[15]}}, b};
        return sa * sb;
    endfunction

    function automatic logic [ACW-1:0] widen_product(input mul_pkg::wb_data_t p);
        return {{(ACW - 32){p[31]}}, p};
    endfunction

    // accumulator bits above 31 sign-extended as ACC_HI shows them
    function automatic mul_pkg::wb_data_t acc_upper(input logic [ACW-1:0] v);
        return {{(64 - ACW){v[ACW-1]}}, v[ACW-1:32]};
    endfunction

    task automatic expect_reg(input string name, input mul_pkg::wb_addr_t addr,
                              input mul_pkg::wb_data_t exp_v);
        mul_pkg::wb_data_t got_v;
        bus_read(addr, got_v);
        chk_name_q.push_back(name);
        chk_exp_q.push_back(exp_v);
        chk_got_q.push_back(got_v);
    endtask

    // one multiply followed by the load or add rule on the model
    task automatic run_op(input mul_pkg::wb_data_t a_word, input mul_pkg::wb_data_t b_word,
                          input logic use_accum);
        mul_pkg::wb_data_t cmd;
        mul_pkg::wb_data_t st;
        cmd = '0;
        cmd[mul_pkg::CMD_START] = 1'b1;
        cmd[mul_pkg::CMD_ACCUM] = use_accum;
        bus_write(mul_pkg::REG_OP_A, a_word);
        bus_write(mul_pkg::REG_OP_B, b_word);
        bus_write(mul_pkg::REG_CMD, cmd);
        wait_idle(st);
        model_prod = ref_product(a_word[15:0], b_word[15:0]);
        if (use_accum)
        begin
            model_acc = model_acc + widen_product(model_prod);
        end
        else
        begin
            model_acc = widen_product(model_prod);
        end
    endtask

    task automatic check_acc(input string name);
        expect_reg({name, " acc_lo"}, mul_pkg::REG_ACC_LO, model_acc[31:0]);
        expect_reg({name, " acc_hi"}, mul_pkg::REG_ACC_HI, acc_upper(model_acc));
    endtask

    task automatic check_single(input string name);
        expect_reg({name, " prod"}, mul_pkg::REG_PROD, model_prod);
        check_acc(name);
    endtask

    task automatic clear_acc();
        mul_pkg::wb_data_t cmd;
        cmd = '0;
        cmd[mul_pkg::CMD_CLEAR] = 1'b1;
        bus_write(mul_pkg::REG_CMD, cmd);
        model_acc = '0;
    endtask

    // every poll after a START with ACCUM shows exactly one of busy and done
    task automatic poll_after_start(input mul_pkg::wb_data_t a_word,
                                    input mul_pkg::wb_data_t b_word);
        mul_pkg::wb_data_t cmd;
        mul_pkg::wb_data_t st;
        logic              finished;
        int                n;
        cmd = '0;
        cmd[mul_pkg::CMD_START] = 1'b1;
        cmd[mul_pkg::CMD_ACCUM] = 1'b1;
        bus_write(mul_pkg::REG_OP_A, a_word);
        bus_write(mul_pkg::REG_OP_B, b_word);
        bus_write(mul_pkg::REG_CMD, cmd);
        finished = 1'b0;
        n = 0;
        while (!finished && n < IDLE_TIMEOUT)
        begin
            bus_read(mul_pkg::REG_STATUS, st);
            assert (st[mul_pkg::ST_BUSY] != st[mul_pkg::ST_DONE])
            else stop_on_error($sformatf(
                "poll after start: expected exactly one of busy and done, actual 0x%08h",
                st));
            finished = !st[mul_pkg::ST_BUSY] && st[mul_pkg::ST_DONE];
            n++;
        end
        if (!finished)
        begin
            stop_on_error("operation did not complete within the polling timeout");
        end
        model_prod = ref_product(a_word[15:0], b_word[15:0]);
        model_acc  = model_acc + widen_product(model_prod);
    endtask

    // reads are pushed on falling edges and compared on rising edges
    always @(posedge clk)
    begin
        string             name;
        mul_pkg::wb_data_t exp_v;
        mul_pkg::wb_data_t got_v;
        while (chk_name_q.size() > 0)
        begin
            name  = chk_name_q.pop_front();
            exp_v = chk_exp_q.pop_front();
            got_v = chk_got_q.pop_front();
            assert (got_v === exp_v)
            else
            begin
                $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp_v, got_v);
                $display("TEST FAIL");
                $fatal(1);
            end
        end
    end

    initial
    begin
        mul_pkg::wb_data_t w;
        int                n;

        clk       = 1'b0;
        arst_n    = 1'b0;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        lcg_state = LCG_SEED;
        model_acc = '0;
        model_prod = '0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // every address reads zero out of reset
        for (int i = 0; i < 8; i++)
        begin
            expect_reg($sformatf("reset read adr %0d", i), mul_pkg::wb_addr_t'(i), '0);
        end

        // operands keep the low 16 bits only
        for (int i = 0; i < 10; i++)
        begin
            w = rand_word();
            bus_write(mul_pkg::REG_OP_A, w);
            expect_reg("op_a readback", mul_pkg::REG_OP_A, {16'h0, w[15:0]});
            w = rand_word();
            bus_write(mul_pkg::REG_OP_B, w);
            expect_reg("op_b readback", mul_pkg::REG_OP_B, {16'h0, w[15:0]});
        end
        bus_write(3'd7, rand_word());
        expect_reg("unmapped read", 3'd7, '0);

        // corner pairs with upper bus bits set on some of them
        run_op(32'hffff_8000, 32'h0000_8000, 1'b0);
        check_single("corner min x min");
        run_op(32'h0000_8000, 32'h1234_7fff, 1'b0);
        check_single("corner min x max");
        run_op(32'h0000_0000, 32'h0000_ffff, 1'b0);
        check_single("corner zero x minus one");
        run_op(32'h0000_ffff, 32'hffff_ffff, 1'b0);
        check_single("corner minus one x minus one");

        for (int i = 0; i < RAND_PAIRS; i++)
        begin
            run_op(rand_word(), rand_word(), 1'b0);
            check_single($sformatf("random pair %0d", i));
        end

        // accumulate chains
        clear_acc();
        for (int i = 0; i < CHAIN_LEN; i++)
        begin
            run_op(rand_word(), rand_word(), 1'b1);
        end
        check_acc("random accum chain");

        clear_acc();
        for (int i = 0; i < CHAIN_LEN; i++)
        begin
            run_op(32'h0000_8000, 32'h0000_8000, 1'b1);
        end
        // 50 * 2^30 needs the guard bits
        check_acc("guard bit chain");

        // clear then one accumulate leaves a single product
        clear_acc();
        check_acc("after clear");
        run_op(rand_word(), rand_word(), 1'b1);
        check_single("single after clear");

        // done is sticky across STATUS reads
        for (int i = 0; i < 3; i++)
        begin
            expect_reg("status done sticky", mul_pkg::REG_STATUS, 32'h0000_0002);
        end
        poll_after_start(rand_word(), rand_word());
        expect_reg("status after accum", mul_pkg::REG_STATUS, 32'h0000_0002);
        check_acc("accum after poll");

        // let the compare process drain
        n = 0;
        while (chk_name_q.size() != 0 && n < 10)
        begin
            @(negedge clk);
            n++;
        end
        if (chk_name_q.size() != 0)
        begin
            $display("[ERROR] compare queue still held reads at the end of the run");
            $display("TEST FAIL");
            $fatal(1);
        end
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* src.f */
+incdir+tests
hdl/mul_pkg.sv
hdl/baugh_wooley_mul.sv
hdl/mac_datapath.sv
hdl/mul_regs.sv
hdl/mul_top.sv
tests/tb_mul_top.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mul_top \
    -Mdir obj_dir -o sim_tb_mul_top \
    -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_tb_mul_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

exit 0
